/* fetch_queue_top.f */
hw/fetch_front_pkg.sv
hw/iq_csr_pkg.sv
hw/iq_ctrl_if.sv
hw/fetch_filter.sv
hw/inst_queue.sv
hw/iq_csr.sv
hw/fetch_queue_top.sv
tb/fetch_queue_tb.sv

/* hw/fetch_filter.sv */
`default_nettype none

module fetch_filter (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        fetch_valid,
	input  fetch_front_pkg::inst_entry_t fetch_entry,
	output logic                        fetch_ready,
	output logic                        enq_valid,
	input  logic                        enq_ready,
	iq_ctrl_if.filter_port              ctrl
);

	// Last accepted instruction
	logic        last_valid;
	logic [31:0] last_npc;
	logic [31:0] last_inst;

	logic dup_hit;
	logic fetch_fire;

	// Same npc and same word as the previous accepted fetch
	assign dup_hit = ctrl.filter_en & last_valid &
	                 (fetch_entry.npc == last_npc) &
	                 (fetch_entry.inst == last_inst);

	// Full queue stalls duplicates too, keeps fetch_ready tied to queue space
	assign fetch_ready = enq_ready;
	assign fetch_fire  = fetch_valid & enq_ready;

	assign enq_valid     = fetch_valid & ~dup_hit;
	assign ctrl.dup_drop = fetch_fire & dup_hit & ~ctrl.flush;

	always_ff @(posedge clock) begin
		if (reset) begin
			last_valid <= 1'b0;
		end else if (ctrl.flush) begin
			last_valid <= 1'b0;   // Fetch in the flush cycle is discarded
		end else if (fetch_fire) begin
			last_valid <= 1'b1;
		end
	end

	// Payload only, qualified by last_valid
	always_ff @(posedge clock) begin
		if (fetch_fire && !ctrl.flush) begin
			last_npc  <= fetch_entry.npc;
			last_inst <= fetch_entry.inst;
		end
	end

endmodule

`default_nettype wire

/* hw/fetch_front_pkg.sv */
`default_nettype none

package fetch_front_pkg;

	// Queue sizing
	localparam int IQ_DEPTH   = 8;
	localparam int IQ_COUNT_W = 4;                  // Holds 0 to IQ_DEPTH
	localparam int IQ_PTR_W   = $clog2(IQ_DEPTH);

	localparam int XLEN = 32;

	// Prediction record from the branch predictor, 35 bits
	typedef struct packed {
		logic            is_branch;
		logic            is_cond;
		logic            pred_taken;
		logic [XLEN-1:0] pred_target;
	} branch_info_t;

	// One queued instruction, 99 bits
	typedef struct packed {
		logic [XLEN-1:0] npc;    // Next PC
		logic [31:0]     inst;   // Raw instruction word
		branch_info_t    br;
	} inst_entry_t;

endpackage

`default_nettype wire

/* hw/fetch_queue_top.sv */
`default_nettype none

module fetch_queue_top (
	input  logic                         clock,
	input  logic                         reset,

	// APB configuration port
	input  logic                         psel,
	input  logic                         penable,
	input  logic                         pwrite,
	input  logic [7:0]                   paddr,
	input  logic [31:0]                  pwdata,
	output logic [31:0]                  prdata,
	output logic                         pready,
	output logic                         pslverr,

	// From fetch
	input  logic                         fetch_valid,
	input  fetch_front_pkg::inst_entry_t fetch_entry,
	output logic                         fetch_ready,

	// To decode
	output logic                         deq_valid,
	output fetch_front_pkg::inst_entry_t deq_entry,
	input  logic                         dispatch_ready,

	input  logic                         branch_mispredict,
	output logic                         iq_almost_full
);

	iq_ctrl_if ctrl_if ();

	logic enq_valid;
	logic enq_ready;

	fetch_filter i_fetch_filter (
		.clock       (clock),
		.reset       (reset),
		.fetch_valid (fetch_valid),
		.fetch_entry (fetch_entry),
		.fetch_ready (fetch_ready),
		.enq_valid   (enq_valid),
		.enq_ready   (enq_ready),
		.ctrl        (ctrl_if.filter_port)
	);

	// Entry payload bypasses the filter, only valid is gated
	inst_queue i_inst_queue (
		.clock             (clock),
		.reset             (reset),
		.enq_valid         (enq_valid),
		.enq_entry         (fetch_entry),
		.enq_ready         (enq_ready),
		.deq_valid         (deq_valid),
		.deq_entry         (deq_entry),
		.dispatch_ready    (dispatch_ready),
		.branch_mispredict (branch_mispredict),
		.almost_full       (iq_almost_full),
		.ctrl              (ctrl_if.queue_port)
	);

	iq_csr i_iq_csr (
		.clock   (clock),
		.reset   (reset),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.ctrl    (ctrl_if.csr)
	);

endmodule

`default_nettype wire

/* hw/inst_queue.sv */
`default_nettype none

module inst_queue (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         enq_valid,
	input  fetch_front_pkg::inst_entry_t enq_entry,
	output logic                         enq_ready,
	output logic                         deq_valid,
	output fetch_front_pkg::inst_entry_t deq_entry,
	input  logic                         dispatch_ready,
	input  logic                         branch_mispredict,
	output logic                         almost_full,
	iq_ctrl_if.queue_port                ctrl
);

	fetch_front_pkg::inst_entry_t mem [fetch_front_pkg::IQ_DEPTH];

	logic [fetch_front_pkg::IQ_PTR_W-1:0]   head;
	logic [fetch_front_pkg::IQ_PTR_W-1:0]   tail;
	logic [fetch_front_pkg::IQ_COUNT_W-1:0] count;

	logic is_full;
	logic is_empty;
	logic do_enq;
	logic do_deq;

	// Wrap at IQ_DEPTH, works for any depth
	function automatic logic [fetch_front_pkg::IQ_PTR_W-1:0] ptr_inc(
		input logic [fetch_front_pkg::IQ_PTR_W-1:0] ptr
	);
		logic [fetch_front_pkg::IQ_PTR_W-1:0] last;
		last = fetch_front_pkg::IQ_PTR_W'(fetch_front_pkg::IQ_DEPTH - 1);
		if (ptr == last)
			ptr_inc = '0;
		else
			ptr_inc = ptr + 1'b1;
	endfunction

	assign is_full  = (count == fetch_front_pkg::IQ_COUNT_W'(fetch_front_pkg::IQ_DEPTH));
	assign is_empty = (count == '0);

	// Full is judged on current count, same-cycle dequeue does not reopen it
	assign enq_ready = ~is_full;
	assign deq_valid = ~is_empty & ~ctrl.dispatch_hold;
	assign deq_entry = mem[head];   // Head straight from storage

	// Mispredict discards both the offered fetch and any handover
	assign do_enq = enq_valid & enq_ready & ~branch_mispredict;
	assign do_deq = deq_valid & dispatch_ready & ~branch_mispredict;

	assign ctrl.flush     = branch_mispredict;
	assign ctrl.occupancy = count;
	assign almost_full    = (count >= ctrl.watermark);

	// Pointers and count
	always_ff @(posedge clock) begin
		if (reset || branch_mispredict) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (do_enq)
				tail <= ptr_inc(tail);
			if (do_deq)
				head <= ptr_inc(head);

			case ({do_enq, do_deq})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // Both or neither
			endcase
		end
	end

	// Entry storage
	always_ff @(posedge clock) begin
		if (do_enq)
			mem[tail] <= enq_entry;
	end

endmodule

`default_nettype wire

/* hw/iq_csr.sv */
`default_nettype none

module iq_csr (
	input  logic        clock,
	input  logic        reset,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [7:0]  paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	iq_ctrl_if.csr      ctrl
);

	logic [iq_csr_pkg::CTRL_W-1:0]           ctrl_q;
	logic [fetch_front_pkg::IQ_COUNT_W-1:0]  watermark_q;
	logic [iq_csr_pkg::COUNTER_W-1:0]        dup_count;
	logic [iq_csr_pkg::COUNTER_W-1:0]        flush_count;

	logic access;
	logic wr_en;
	logic addr_hit;

	assign pready = 1'b1;   // No wait states
	assign access = psel & penable;
	assign wr_en  = access & pwrite;

	always_comb begin
		case (paddr)
			iq_csr_pkg::ADDR_CTRL,
			iq_csr_pkg::ADDR_WATERMARK,
			iq_csr_pkg::ADDR_STATUS,
			iq_csr_pkg::ADDR_DUP_COUNT,
			iq_csr_pkg::ADDR_FLUSH_COUNT: addr_hit = 1'b1;
			default:                      addr_hit = 1'b0;
		endcase
	end

	// STATUS is read only
	assign pslverr = access &
	                 (~addr_hit | (pwrite & (paddr == iq_csr_pkg::ADDR_STATUS)));

	// Read mux
	always_comb begin
		prdata = '0;
		if (psel && !pwrite) begin
			case (paddr)
				iq_csr_pkg::ADDR_CTRL:        prdata = 32'(ctrl_q);
				iq_csr_pkg::ADDR_WATERMARK:   prdata = 32'(watermark_q);
				iq_csr_pkg::ADDR_STATUS:      prdata = 32'(ctrl.occupancy);
				iq_csr_pkg::ADDR_DUP_COUNT:   prdata = 32'(dup_count);
				iq_csr_pkg::ADDR_FLUSH_COUNT: prdata = 32'(flush_count);
				default:                      prdata = '0;
			endcase
		end
	end

	// Control and watermark
	always_ff @(posedge clock) begin
		if (reset) begin
			ctrl_q      <= iq_csr_pkg::CTRL_RESET;
			watermark_q <= iq_csr_pkg::WATERMARK_RESET;
		end else if (wr_en) begin
			if (paddr == iq_csr_pkg::ADDR_CTRL)
				ctrl_q <= pwdata[iq_csr_pkg::CTRL_W-1:0];
			if (paddr == iq_csr_pkg::ADDR_WATERMARK)
				watermark_q <= pwdata[fetch_front_pkg::IQ_COUNT_W-1:0];
		end
	end

	// Saturating counters, any write clears
	always_ff @(posedge clock) begin
		if (reset) begin
			dup_count   <= '0;
			flush_count <= '0;
		end else begin
			if (wr_en && paddr == iq_csr_pkg::ADDR_DUP_COUNT)
				dup_count <= '0;   // Clear wins over a same-cycle pulse
			else if (ctrl.dup_drop && dup_count != '1)
				dup_count <= dup_count + 1'b1;

			if (wr_en && paddr == iq_csr_pkg::ADDR_FLUSH_COUNT)
				flush_count <= '0;
			else if (ctrl.flush && flush_count != '1)
				flush_count <= flush_count + 1'b1;
		end
	end

	assign ctrl.filter_en     = ctrl_q[iq_csr_pkg::CTRL_FILTER_EN_BIT];
	assign ctrl.dispatch_hold = ctrl_q[iq_csr_pkg::CTRL_HOLD_BIT];
	assign ctrl.watermark     = watermark_q;

endmodule

`default_nettype wire

/* hw/iq_csr_pkg.sv */
`default_nettype none

package iq_csr_pkg;

	// APB register offsets
	localparam logic [7:0] ADDR_CTRL        = 8'h00;
	localparam logic [7:0] ADDR_WATERMARK   = 8'h04;
	localparam logic [7:0] ADDR_STATUS      = 8'h08;
	localparam logic [7:0] ADDR_DUP_COUNT   = 8'h0C;
	localparam logic [7:0] ADDR_FLUSH_COUNT = 8'h10;

	// CTRL fields
	localparam int CTRL_W             = 2;
	localparam int CTRL_FILTER_EN_BIT = 0;
	localparam int CTRL_HOLD_BIT      = 1;

	// Filter on, dispatch not held
	localparam logic [CTRL_W-1:0] CTRL_RESET = 2'b01;

	// Watermark compares against occupancy, so same width
	localparam logic [fetch_front_pkg::IQ_COUNT_W-1:0] WATERMARK_RESET = 6;

	localparam int COUNTER_W = 16;   // Dup and flush counters

endpackage

`default_nettype wire

/* hw/iq_ctrl_if.sv */
`default_nettype none

interface iq_ctrl_if;

	// Control from the register block
	logic                                  filter_en;
	logic                                  dispatch_hold;
	logic [fetch_front_pkg::IQ_COUNT_W-1:0] watermark;

	// Status from the data path
	logic [fetch_front_pkg::IQ_COUNT_W-1:0] occupancy;
	logic                                  dup_drop;   // One cycle per dropped fetch
	logic                                  flush;      // One cycle per mispredict

	modport csr (
		output filter_en, dispatch_hold, watermark,
		input  occupancy, dup_drop, flush
	);

	// Filter also watches flush to forget the last instruction
	modport filter_port (
		input  filter_en, flush,
		output dup_drop
	);

	modport queue_port (
		input  dispatch_hold, watermark,
		output occupancy, flush
	);

endinterface

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the instruction queue testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module fetch_queue_tb -f fetch_queue_top.f \
	--Mdir obj_dir -o fetch_queue_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/fetch_queue_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation run failed with status $status"
	exit "$status"
fi

echo "Simulation run completed"
exit 0

/* tb/fetch_queue_tb.sv */
`default_nettype none

module fetch_queue_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD     = 4;
	localparam int RESET_CYCLES   = 10;
	localparam int TRAFFIC_CYCLES = 300;
	localparam int APB_OPS        = 26;
	localparam int TOTAL_CYCLES   = RESET_CYCLES + 4 * (TRAFFIC_CYCLES + 1) + 3 * APB_OPS +
	                                3 * (fetch_front_pkg::IQ_DEPTH + 3) + 4;

	logic                         clock = 1'b0;
	logic                         reset;
	logic                         psel;
	logic                         penable;
	logic                         pwrite;
	logic [7:0]                   paddr;
	logic [31:0]                  pwdata;
	logic [31:0]                  prdata;
	logic                         pready;
	logic                         pslverr;
	logic                         fetch_valid;
	fetch_front_pkg::inst_entry_t fetch_entry;
	logic                         fetch_ready;
	logic                         deq_valid;
	fetch_front_pkg::inst_entry_t deq_entry;
	logic                         dispatch_ready;
	logic                         branch_mispredict;
	logic                         iq_almost_full;

	// Reference model state
	fetch_front_pkg::inst_entry_t model [$];
	fetch_front_pkg::inst_entry_t exp_front;
	int                           exp_count;
	logic                         last_flush;
	logic                         have_last;
	logic [31:0]                  last_npc;
	logic [31:0]                  last_inst;
	int                           dup_drops   = 0;
	int                           mispredicts = 0;
	int                           dup_base    = 0;   // Counter values at the last clear
	int                           flush_base  = 0;

	// Register state as programmed over APB
	logic        cfg_filter_en = 1'b1;
	logic        cfg_hold      = 1'b0;
	int          cfg_watermark = 6;
	logic [31:0] rd_expect;
	logic        err_expect;

	logic exp_deq_valid;
	logic exp_fetch_ready;
	logic exp_almost_full;
	logic exp_pslverr;

	assign exp_deq_valid   = (exp_count != 0) && !cfg_hold;
	assign exp_fetch_ready = (exp_count != fetch_front_pkg::IQ_DEPTH);
	assign exp_almost_full = (exp_count >= cfg_watermark);
	assign exp_pslverr     = psel && penable && err_expect;

	fetch_queue_top i_fetch_queue_top (.*);

	always #(CLK_PERIOD / 2) clock = ~clock;

	task automatic report_failure();
		$display("sim failed");
		$fatal(1, "Stopping at the first error");
	endtask

	// Mirrors every accepted fetch and every handover
	always @(posedge clock) begin
		logic deq_fire;
		logic enq_fire;
		logic is_dup;
		if (reset || branch_mispredict) begin
			model.delete();
			have_last = 1'b0;
			if (branch_mispredict && !reset)
				mispredicts++;
		end else begin
			deq_fire = (model.size() != 0) && !cfg_hold && dispatch_ready;
			enq_fire = fetch_valid && (model.size() < fetch_front_pkg::IQ_DEPTH);
			is_dup   = cfg_filter_en && have_last &&
			           (fetch_entry.npc == last_npc) && (fetch_entry.inst == last_inst);
			if (deq_fire)
				void'(model.pop_front());
			if (enq_fire) begin
				if (is_dup)
					dup_drops++;   // Consumed without enqueue
				else
					model.push_back(fetch_entry);
				have_last = 1'b1;
				last_npc  = fetch_entry.npc;
				last_inst = fetch_entry.inst;
			end
		end
		exp_count  <= model.size();
		exp_front  <= (model.size() != 0) ? model[0] : '0;
		last_flush <= branch_mispredict && !reset;
	end

	assert property (@(posedge clock) disable iff (reset)
		(deq_valid && dispatch_ready) |-> (deq_entry == exp_front))
	else begin
		$display("Mismatch at %0t: deq_entry expected %h got %h", $time,
		         $sampled(exp_front), $sampled(deq_entry));
		report_failure();
	end

	assert property (@(posedge clock) disable iff (reset) deq_valid == exp_deq_valid)
	else begin
		$display("Mismatch at %0t: deq_valid expected %b got %b", $time,
		         $sampled(exp_deq_valid), $sampled(deq_valid));
		report_failure();
	end

	assert property (@(posedge clock) disable iff (reset) last_flush |-> !deq_valid)
	else begin
		$display("Mismatch at %0t: deq_valid expected 0 got %b after flush", $time,
		         $sampled(deq_valid));
		report_failure();
	end

	assert property (@(posedge clock) disable iff (reset) fetch_ready == exp_fetch_ready)
	else begin
		$display("Mismatch at %0t: fetch_ready expected %b got %b", $time,
		         $sampled(exp_fetch_ready), $sampled(fetch_ready));
		report_failure();
	end

	assert property (@(posedge clock) disable iff (reset) iq_almost_full == exp_almost_full)
	else begin
		$display("Mismatch at %0t: iq_almost_full expected %b got %b", $time,
		         $sampled(exp_almost_full), $sampled(iq_almost_full));
		report_failure();
	end

	assert property (@(posedge clock) disable iff (reset)
		(psel && penable && !pwrite) |-> (prdata == rd_expect))
	else begin
		$display("Mismatch at %0t: prdata expected %h got %h", $time,
		         $sampled(rd_expect), $sampled(prdata));
		report_failure();
	end

	assert property (@(posedge clock) disable iff (reset) pslverr == exp_pslverr)
	else begin
		$display("Mismatch at %0t: pslverr expected %b got %b", $time,
		         $sampled(exp_pslverr), $sampled(pslverr));
		report_failure();
	end

	assert property (@(posedge clock) disable iff (reset) psel |-> pready)
	else begin
		$display("Mismatch at %0t: pready expected 1 got %b", $time, $sampled(pready));
		report_failure();
	end

	// Setup phase, access phase, then idle
	task automatic apb_access(input logic write, input logic [7:0] addr,
	                          input logic [31:0] wdata, input logic [31:0] expect_rdata,
	                          input logic expect_err);
		@(posedge clock);
		psel       <= 1'b1;
		penable    <= 1'b0;
		pwrite     <= write;
		paddr      <= addr;
		pwdata     <= wdata;
		rd_expect  <= expect_rdata;
		err_expect <= expect_err;
		@(posedge clock);
		penable <= 1'b1;
		@(posedge clock);   // Write lands here
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic check_read(input logic [7:0] addr, input logic [31:0] value);
		apb_access(1'b0, addr, 32'h0, value, 1'b0);
	endtask

	task automatic check_slave_error(input logic write, input logic [7:0] addr);
		apb_access(write, addr, 32'hdead_beef, 32'h0, 1'b1);
	endtask

	task automatic write_ctrl(input logic filter_en, input logic hold);
		apb_access(1'b1, iq_csr_pkg::ADDR_CTRL,
		           (32'(filter_en) << iq_csr_pkg::CTRL_FILTER_EN_BIT) |
		           (32'(hold) << iq_csr_pkg::CTRL_HOLD_BIT), 32'h0, 1'b0);
		cfg_filter_en <= filter_en;
		cfg_hold      <= hold;
	endtask

	task automatic write_watermark(input int level);
		apb_access(1'b1, iq_csr_pkg::ADDR_WATERMARK, 32'(level), 32'h0, 1'b0);
		cfg_watermark <= level;
	endtask

	function automatic fetch_front_pkg::inst_entry_t random_entry();
		fetch_front_pkg::inst_entry_t e;
		logic [31:0] flags;
		flags               = $urandom();
		e.npc               = $urandom();
		e.inst              = $urandom();
		e.br.is_branch      = flags[0];
		e.br.is_cond        = flags[1];
		e.br.pred_taken     = flags[2];
		e.br.pred_target    = $urandom();
		return e;
	endfunction

	// Random fetch and decode traffic where a quarter of the offers repeat the last one
	task automatic run_traffic(input int cycles, input logic with_mispredict);
		logic [31:0]                  rnd;
		fetch_front_pkg::inst_entry_t offered;
		offered = random_entry();
		for (int i = 0; i < cycles; i++) begin
			rnd = $urandom();
			if (rnd[5:4] != 2'b00)
				offered = random_entry();
			@(posedge clock);
			fetch_valid       <= (rnd[2:0] != 3'b000);
			fetch_entry       <= offered;
			dispatch_ready    <= rnd[3];
			branch_mispredict <= with_mispredict && (rnd[10:6] == 5'd0);
		end
		@(posedge clock);
		fetch_valid       <= 1'b0;
		dispatch_ready    <= 1'b0;
		branch_mispredict <= 1'b0;
	endtask

	task automatic drain_queue();
		@(posedge clock);
		dispatch_ready <= 1'b1;
		do
			@(posedge clock);
		while (exp_count != 0);
		dispatch_ready <= 1'b0;
	endtask

	initial begin
		#(TOTAL_CYCLES * CLK_PERIOD + 200);
		$display("Timeout: the test sequence did not complete in time");
		report_failure();
	end

	initial begin
		void'($urandom(32'h89e6));
		reset             = 1'b1;
		psel              = 1'b0;
		penable           = 1'b0;
		pwrite            = 1'b0;
		paddr             = 8'h0;
		pwdata            = 32'h0;
		fetch_valid       = 1'b0;
		fetch_entry       = '0;
		dispatch_ready    = 1'b0;
		branch_mispredict = 1'b0;
		rd_expect         = 32'h0;
		err_expect        = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;

		check_read(iq_csr_pkg::ADDR_CTRL, 32'(iq_csr_pkg::CTRL_RESET));
		check_read(iq_csr_pkg::ADDR_WATERMARK, 32'(iq_csr_pkg::WATERMARK_RESET));
		check_read(iq_csr_pkg::ADDR_STATUS, 32'h0);
		check_read(iq_csr_pkg::ADDR_DUP_COUNT, 32'h0);
		check_read(iq_csr_pkg::ADDR_FLUSH_COUNT, 32'h0);
		check_slave_error(1'b0, 8'h14);
		check_slave_error(1'b1, iq_csr_pkg::ADDR_STATUS);
		check_slave_error(1'b1, 8'h40);

		// Filter on, reset watermark
		run_traffic(TRAFFIC_CYCLES, 1'b0);
		drain_queue();
		check_read(iq_csr_pkg::ADDR_DUP_COUNT, dup_drops - dup_base);
		check_read(iq_csr_pkg::ADDR_STATUS, 32'h0);

		write_watermark(3);
		check_read(iq_csr_pkg::ADDR_WATERMARK, 32'h3);
		run_traffic(TRAFFIC_CYCLES, 1'b1);
		@(posedge clock);
		branch_mispredict <= 1'b1;   // One flush with entries likely present
		@(posedge clock);
		branch_mispredict <= 1'b0;
		check_read(iq_csr_pkg::ADDR_STATUS, 32'h0);
		check_read(iq_csr_pkg::ADDR_FLUSH_COUNT, mispredicts - flush_base);
		check_read(iq_csr_pkg::ADDR_DUP_COUNT, dup_drops - dup_base);

		apb_access(1'b1, iq_csr_pkg::ADDR_DUP_COUNT, 32'h1234, 32'h0, 1'b0);
		dup_base = dup_drops;
		check_read(iq_csr_pkg::ADDR_DUP_COUNT, 32'h0);
		apb_access(1'b1, iq_csr_pkg::ADDR_FLUSH_COUNT, 32'h0, 32'h0, 1'b0);
		flush_base = mispredicts;
		check_read(iq_csr_pkg::ADDR_FLUSH_COUNT, 32'h0);

		// Filter off so repeats go into the queue
		write_ctrl(1'b0, 1'b0);
		check_read(iq_csr_pkg::ADDR_CTRL, 32'h0);
		run_traffic(TRAFFIC_CYCLES, 1'b0);
		drain_queue();
		check_read(iq_csr_pkg::ADDR_DUP_COUNT, dup_drops - dup_base);

		// Dispatch held while fetch fills the queue
		write_ctrl(1'b1, 1'b1);
		check_read(iq_csr_pkg::ADDR_CTRL, 32'h3);
		run_traffic(TRAFFIC_CYCLES, 1'b0);
		write_ctrl(1'b1, 1'b0);
		drain_queue();
		check_read(iq_csr_pkg::ADDR_STATUS, 32'h0);

		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire
